// ==== spartan_params.svh ====
`ifndef SPARTAN_PARAMS_SVH
`define SPARTAN_PARAMS_SVH

// Memory geometry shared by the RAM, the engine and the package types

// Number of words in the dual-port RAM
`define SPARTAN_NUMWORDS 256

// Word address width, enough to reach every word
`define SPARTAN_ADDRW 8

// Data word width in bits
// Must stay a multiple of 8 so byte strobes map cleanly
`define SPARTAN_DATAW 32

`endif

// ==== spartan_pkg.sv ====
`default_nettype none

`include "spartan_params.svh"

package spartan_pkg;

    // One RAM data word
    typedef logic [`SPARTAN_DATAW-1:0] word_t;

    // Word address into the RAM
    typedef logic [`SPARTAN_ADDRW-1:0] addr_t;

    // Byte strobes, one bit per byte lane of word_t
    typedef logic [`SPARTAN_DATAW/8-1:0] be_t;

    // Engine job kinds
    // Fill writes a pattern, sum reads back and adds up the words
    typedef enum logic {
        op_fill = 1'b0,
        op_sum  = 1'b1
    } engine_op_t;

endpackage

`default_nettype wire

// ==== spartan_dpram.sv ====
`default_nettype none

`include "spartan_params.svh"

module spartan_dpram
    import spartan_pkg::*;
(
    input  logic  clock_a,

    // Port A, bus side
    input  logic  ce_a,
    input  logic  wren_a,
    input  addr_t address_a,
    input  word_t byteena_a,
    input  word_t data_a,
    output word_t q_a,

    // Port B, engine side
    input  logic  ce_b,
    input  logic  wren_b,
    input  addr_t address_b,
    input  word_t byteena_b,
    input  word_t data_b,
    output word_t q_b
);

    // Storage array, contents are never cleared
    word_t mem [0:`SPARTAN_NUMWORDS-1];

    // Write side of both ports
    // Each write keeps old bits wherever the mask bit is low
    always_ff @(posedge clock_a) begin
        if (ce_a && wren_a) begin
            mem[address_a] <= (data_a & byteena_a) | (mem[address_a] & ~byteena_a);
        end
        // Same-word collision is left undefined, port B simply lands last
        if (ce_b && wren_b) begin
            mem[address_b] <= (data_b & byteena_b) | (mem[address_b] & ~byteena_b);
        end
    end

    // Registered read, port A
    // Old contents are seen when a write hits the same edge
    always_ff @(posedge clock_a) begin
        if (ce_a) begin
            q_a <= mem[address_a];
        end
    end

    // Registered read, port B
    // Output holds while the port is idle
    always_ff @(posedge clock_a) begin
        if (ce_b) begin
            q_b <= mem[address_b];
        end
    end

endmodule

`default_nettype wire

// ==== spartan_bus_slave.sv ====
`default_nettype none

module spartan_bus_slave
    import spartan_pkg::*;
(
    input  logic  clock_a,
    input  logic  rst_n,

    // Processor-side bus
    input  logic  bus_sel,
    input  logic  bus_wr,
    input  addr_t bus_addr,
    input  word_t bus_wdata,
    input  be_t   bus_be,
    output logic  bus_ack,
    output word_t bus_rdata,

    // RAM port A
    output logic  ce_a,
    output logic  wren_a,
    output addr_t address_a,
    output word_t data_a,
    output word_t byteena_a,
    input  word_t q_a
);

    // Read ack in flight, q_a carries the data this cycle
    logic  rd_ack;
    // Last read word, kept once q_a moves on
    word_t rdata_hold;

    // Strobed access goes straight to the RAM
    assign ce_a      = bus_sel;
    assign wren_a    = bus_sel && bus_wr;
    assign address_a = bus_addr;
    assign data_a    = bus_wdata;

    // Byte strobes to bit mask
    // Each strobe bit covers its eight data bits
    always_comb begin
        for (int i = 0; i < $bits(be_t); i++) begin
            byteena_a[8*i +: 8] = {8{bus_be[i]}};
        end
    end

    // Ack one cycle after the strobe
    // Also note whether that access was a read
    always_ff @(posedge clock_a) begin
        if (!rst_n) begin
            bus_ack <= 1'b0;
            rd_ack  <= 1'b0;
        end else begin
            bus_ack <= bus_sel;
            rd_ack  <= bus_sel && !bus_wr;
        end
    end

    // Keep the read word past the ack cycle
    // Later writes reload q_a with stale data
    always_ff @(posedge clock_a) begin
        if (rd_ack) begin
            rdata_hold <= q_a;
        end
    end

    // Live RAM data during the read ack, held copy afterwards
    assign bus_rdata = rd_ack ? q_a : rdata_hold;

endmodule

`default_nettype wire

// ==== spartan_mem_engine.sv ====
`default_nettype none

`include "spartan_params.svh"

module spartan_mem_engine
    import spartan_pkg::*;
(
    input  logic                    clock_a,
    input  logic                    rst_n,

    // Job request and status
    input  logic                    eng_start,
    input  engine_op_t              eng_op,
    input  addr_t                   eng_base,
    input  logic [`SPARTAN_ADDRW:0] eng_count,
    input  word_t                   eng_pattern,
    output logic                    eng_busy,
    output logic                    eng_done,
    output word_t                   eng_sum,

    // RAM port B
    output logic                    ce_b,
    output logic                    wren_b,
    output addr_t                   address_b,
    output word_t                   data_b,
    output word_t                   byteena_b,
    input  word_t                   q_b
);

    // FSM encoding
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_run   = 2'd1;
    localparam logic [1:0] st_drain = 2'd2;

    // Memory size in count width
    localparam logic [`SPARTAN_ADDRW:0] num_words = (`SPARTAN_ADDRW+1)'(`SPARTAN_NUMWORDS);

    logic [1:0]              state;
    // Words left after the current one
    logic [`SPARTAN_ADDRW:0] remaining;
    // Words between base and top of memory
    logic [`SPARTAN_ADDRW:0] room;
    logic [`SPARTAN_ADDRW:0] clip_count;
    addr_t                   cur_addr;
    engine_op_t              op_q;
    word_t                   pattern_q;
    logic                    start_ok;
    logic                    last_step;
    // Read pipeline, issue stage and return stage
    logic                    rd_issue;
    logic                    rd_vld;

    // Start only counts when idle
    assign start_ok = (state == st_idle) && eng_start;

    // Clip the region at the top of memory, no wrap
    assign room       = num_words - {1'b0, eng_base};
    assign clip_count = (eng_count > room) ? room : eng_count;

    assign last_step = (remaining == '0);

    // One RAM access per run cycle
    assign ce_b      = (state == st_run);
    assign wren_b    = ce_b && (op_q == op_fill);
    assign rd_issue  = ce_b && (op_q == op_sum);
    assign address_b = cur_addr;
    assign data_b    = pattern_q;
    // Engine always writes whole words
    assign byteena_b = '1;

    // Busy drops in the same cycle done pulses
    assign eng_busy = (state != st_idle);

    // Control FSM
    always_ff @(posedge clock_a) begin
        if (!rst_n) begin
            state     <= st_idle;
            remaining <= '0;
            eng_done  <= 1'b0;
            rd_vld    <= 1'b0;
        end else begin
            eng_done <= 1'b0;
            // Data for a read issued now shows on q_b next cycle
            rd_vld   <= rd_issue;
            case (state)
                st_idle: begin
                    if (start_ok) begin
                        state     <= st_run;
                        remaining <= clip_count - 1'b1;
                    end
                end
                st_run: begin
                    remaining <= remaining - 1'b1;
                    if (last_step) begin
                        if (op_q == op_fill) begin
                            // Last write lands at this edge
                            state    <= st_idle;
                            eng_done <= 1'b1;
                        end else begin
                            state <= st_drain;
                        end
                    end
                end
                st_drain: begin
                    // Final return is added at this edge
                    // Pipeline is empty after it
                    state    <= st_idle;
                    eng_done <= 1'b1;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Job parameters and address counter
    always_ff @(posedge clock_a) begin
        if (start_ok) begin
            cur_addr  <= eng_base;
            op_q      <= eng_op;
            pattern_q <= eng_pattern;
        end else if (ce_b) begin
            cur_addr <= cur_addr + 1'b1;
        end
    end

    // Checksum accumulator
    // Wrapping 32-bit add of each returned word
    always_ff @(posedge clock_a) begin
        if (!rst_n) begin
            eng_sum <= '0;
        end else if (start_ok) begin
            eng_sum <= '0;
        end else if (rd_vld) begin
            eng_sum <= eng_sum + q_b;
        end
    end

endmodule

`default_nettype wire

// ==== spartan_ram_top.sv ====
`default_nettype none

`include "spartan_params.svh"

module spartan_ram_top
    import spartan_pkg::*;
(
    input  logic                    clock_a,
    input  logic                    rst_n,

    // Processor-side bus
    input  logic                    bus_sel,
    input  logic                    bus_wr,
    input  addr_t                   bus_addr,
    input  word_t                   bus_wdata,
    input  be_t                     bus_be,
    output logic                    bus_ack,
    output word_t                   bus_rdata,

    // Memory engine control
    input  logic                    eng_start,
    input  engine_op_t              eng_op,
    input  addr_t                   eng_base,
    input  logic [`SPARTAN_ADDRW:0] eng_count,
    input  word_t                   eng_pattern,
    output logic                    eng_busy,
    output logic                    eng_done,
    output word_t                   eng_sum
);

    // Port A nets, bus slave side
    logic  ce_a;
    logic  wren_a;
    addr_t address_a;
    word_t data_a;
    word_t byteena_a;
    word_t q_a;

    // Port B nets, engine side
    logic  ce_b;
    logic  wren_b;
    addr_t address_b;
    word_t data_b;
    word_t byteena_b;
    word_t q_b;

    // Bus adapter on RAM port A
    spartan_bus_slave u_bus (
        .clock_a   (clock_a),
        .rst_n     (rst_n),
        .bus_sel   (bus_sel),
        .bus_wr    (bus_wr),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_be    (bus_be),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata),
        .ce_a      (ce_a),
        .wren_a    (wren_a),
        .address_a (address_a),
        .data_a    (data_a),
        .byteena_a (byteena_a),
        .q_a       (q_a)
    );

    // Fill and checksum engine on RAM port B
    spartan_mem_engine u_eng (
        .clock_a     (clock_a),
        .rst_n       (rst_n),
        .eng_start   (eng_start),
        .eng_op      (eng_op),
        .eng_base    (eng_base),
        .eng_count   (eng_count),
        .eng_pattern (eng_pattern),
        .eng_busy    (eng_busy),
        .eng_done    (eng_done),
        .eng_sum     (eng_sum),
        .ce_b        (ce_b),
        .wren_b      (wren_b),
        .address_b   (address_b),
        .data_b      (data_b),
        .byteena_b   (byteena_b),
        .q_b         (q_b)
    );

    // Shared dual-port storage
    spartan_dpram u_ram (
        .clock_a   (clock_a),
        .ce_a      (ce_a),
        .wren_a    (wren_a),
        .address_a (address_a),
        .byteena_a (byteena_a),
        .data_a    (data_a),
        .q_a       (q_a),
        .ce_b      (ce_b),
        .wren_b    (wren_b),
        .address_b (address_b),
        .byteena_b (byteena_b),
        .data_b    (data_b),
        .q_b       (q_b)
    );

endmodule

`default_nettype wire

// ==== tb_spartan_checker.sv ====
`default_nettype none

`include "spartan_params.svh"

module tb_spartan_checker
    import spartan_pkg::*;
(
    input  logic                    clock_a,
    input  logic                    rst_n,
    input  logic                    bus_sel,
    input  logic                    bus_wr,
    input  addr_t                   bus_addr,
    input  word_t                   bus_wdata,
    input  be_t                     bus_be,
    input  logic                    bus_ack,
    input  word_t                   bus_rdata,
    input  logic                    eng_start,
    input  engine_op_t              eng_op,
    input  addr_t                   eng_base,
    input  logic [`SPARTAN_ADDRW:0] eng_count,
    input  word_t                   eng_pattern,
    input  logic                    eng_busy,
    input  logic                    eng_done,
    input  word_t                   eng_sum,
    // Read expectation from the stimulus table, used only when exp_fixed is set
    input  logic                    exp_fixed,
    input  word_t                   exp_value,
    output int                      pass_count,
    output int                      fail_count
);
    timeunit 1ns;
    timeprecision 100ps;

    // Shadow copy of the RAM
    word_t      shadow [0:`SPARTAN_NUMWORDS-1];
    int         n_pass = 0;
    int         n_fail = 0;
    logic       rst_d = 1'b0;
    // Strobe seen last edge, ack is due now
    logic       sel_d = 1'b0;
    logic       rd_d = 1'b0;
    addr_t      acc_addr;
    word_t      rd_expect;
    // Last word a read returned, bus_rdata keeps it until the next read
    word_t      held_rdata;
    logic       have_read = 1'b0;
    // Engine job as accepted at its start pulse
    logic       running = 1'b0;
    engine_op_t job_op;
    int         job_base;
    int         job_len;
    int         job_cycles;
    word_t      job_pattern;

    assign pass_count = n_pass;
    assign fail_count = n_fail;

    // Strobed byte lanes take new data, others keep the old word
    function automatic word_t merge_bytes(word_t old_word, word_t new_word, be_t be);
        word_t merged;
        merged = old_word;
        for (int b = 0; b < $bits(be_t); b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // Regions stop at the top of memory
    function automatic int clip_len(int base, int count);
        return (base + count > `SPARTAN_NUMWORDS) ? `SPARTAN_NUMWORDS - base : count;
    endfunction

    // 32-bit wrapping sum of a shadow region
    function automatic word_t region_sum(int base, int len);
        word_t total;
        total = '0;
        for (int i = 0; i < len; i++) begin
            total += shadow[base + i];
        end
        return total;
    endfunction

    task automatic note_pass(string what);
        n_pass++;
        $display("Pass at %0d ns: %s", $time, what);
    endtask

    task automatic note_fail(string what);
        n_fail++;
        $display("Fail at %0d ns: %s", $time, what);
    endtask

    task automatic compare_word(string sig, word_t expected, word_t actual, string what);
        if (actual !== expected) begin
            n_fail++;
            $display("Fail at %0d ns: %s expected 0x%08h, got 0x%08h (%s)",
                     $time, sig, expected, actual, what);
        end else begin
            note_pass(what);
        end
    endtask

    always @(posedge clock_a) begin
        rst_d <= rst_n;
        if (!rst_n) begin
            sel_d     <= 1'b0;
            rd_d      <= 1'b0;
            running   <= 1'b0;
            have_read <= 1'b0;
        end else begin
            // First edge out of reset
            if (!rst_d) begin
                if (bus_ack !== 1'b0 || eng_busy !== 1'b0 || eng_done !== 1'b0) begin
                    note_fail("bus_ack, eng_busy or eng_done not low after reset");
                end else begin
                    compare_word("eng_sum", '0, eng_sum, "idle outputs after reset");
                end
            end

            // Ack must follow every strobe by exactly one cycle
            if (bus_ack !== sel_d) begin
                note_fail("bus_ack did not come exactly one cycle after bus_sel");
            end else if (bus_ack && rd_d) begin
                compare_word("bus_rdata", rd_expect, bus_rdata,
                             $sformatf("bus read at 0x%02h", acc_addr));
                held_rdata <= rd_expect;
                have_read  <= 1'b1;
            end else begin
                if (bus_ack) begin
                    note_pass($sformatf("bus write at 0x%02h acked", acc_addr));
                end
                // Read data stays put through writes and idle cycles
                if (have_read && bus_rdata !== held_rdata) begin
                    n_fail++;
                    $display("Fail at %0d ns: bus_rdata expected held 0x%08h, got 0x%08h",
                             $time, held_rdata, bus_rdata);
                    have_read <= 1'b0;
                end
            end
            sel_d    <= bus_sel;
            rd_d     <= bus_sel && !bus_wr;
            acc_addr <= bus_addr;
            if (bus_sel && bus_wr) begin
                shadow[bus_addr] = merge_bytes(shadow[bus_addr], bus_wdata, bus_be);
            end
            if (bus_sel && !bus_wr) begin
                rd_expect <= exp_fixed ? exp_value : shadow[bus_addr];
            end

            // Engine job tracking
            if (eng_done) begin
                if (!running) begin
                    note_fail("eng_done pulsed with no job running");
                end else if (job_op == op_fill) begin
                    for (int i = 0; i < job_len; i++) begin
                        shadow[job_base + i] = job_pattern;
                    end
                    note_pass($sformatf("fill of %0d words at 0x%02h", job_len, job_base));
                end else begin
                    compare_word("eng_sum", region_sum(job_base, job_len), eng_sum,
                                 $sformatf("sum of %0d words at 0x%02h", job_len, job_base));
                end
                running <= 1'b0;
            end else if (running) begin
                if (!eng_busy) begin
                    note_fail("eng_busy low while a job is running");
                end
                if (job_cycles > job_len + 4) begin
                    note_fail("eng_done never pulsed for the running job");
                    running <= 1'b0;
                end
                job_cycles <= job_cycles + 1;
            end
            // Start only taken with no job running
            if (eng_start && !running) begin
                job_op      <= eng_op;
                job_base    <= int'(eng_base);
                job_len     <= clip_len(int'(eng_base), int'(eng_count));
                job_pattern <= eng_pattern;
                job_cycles  <= 0;
                running     <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_spartan_ram.sv ====
`default_nettype none

`include "spartan_params.svh"

module tb_spartan_ram
    import spartan_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // Stimulus kinds
    localparam int kind_bus_wr   = 0;
    localparam int kind_bus_rd   = 1;
    localparam int kind_fill     = 2;
    localparam int kind_sum      = 3;
    localparam int kind_rand_wr  = 4;
    // Sum with a second start pulse while busy
    localparam int kind_sum_dup  = 5;
    localparam int max_entries   = 40;

    logic                    clock_a = 1'b0;
    logic                    rst_n;
    logic                    bus_sel;
    logic                    bus_wr;
    addr_t                   bus_addr;
    word_t                   bus_wdata;
    be_t                     bus_be;
    logic                    bus_ack;
    word_t                   bus_rdata;
    logic                    eng_start;
    engine_op_t              eng_op;
    addr_t                   eng_base;
    logic [`SPARTAN_ADDRW:0] eng_count;
    word_t                   eng_pattern;
    logic                    eng_busy;
    logic                    eng_done;
    word_t                   eng_sum;
    logic                    exp_fixed;
    word_t                   exp_value;
    int                      pass_count;
    int                      fail_count;
    int                      tb_errors = 0;
    logic                    table_ready = 1'b0;

    // Stimulus table, one column per array
    int    tab_kind  [max_entries];
    addr_t tab_addr  [max_entries];
    int    tab_count [max_entries];
    word_t tab_data  [max_entries];
    be_t   tab_be    [max_entries];
    logic  tab_fixed [max_entries];
    word_t tab_exp   [max_entries];
    int    n_entries = 0;

    always #50 clock_a = ~clock_a;

    spartan_ram_top dut (
        .clock_a     (clock_a),
        .rst_n       (rst_n),
        .bus_sel     (bus_sel),
        .bus_wr      (bus_wr),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_be      (bus_be),
        .bus_ack     (bus_ack),
        .bus_rdata   (bus_rdata),
        .eng_start   (eng_start),
        .eng_op      (eng_op),
        .eng_base    (eng_base),
        .eng_count   (eng_count),
        .eng_pattern (eng_pattern),
        .eng_busy    (eng_busy),
        .eng_done    (eng_done),
        .eng_sum     (eng_sum)
    );

    tb_spartan_checker chk (
        .clock_a     (clock_a),
        .rst_n       (rst_n),
        .bus_sel     (bus_sel),
        .bus_wr      (bus_wr),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_be      (bus_be),
        .bus_ack     (bus_ack),
        .bus_rdata   (bus_rdata),
        .eng_start   (eng_start),
        .eng_op      (eng_op),
        .eng_base    (eng_base),
        .eng_count   (eng_count),
        .eng_pattern (eng_pattern),
        .eng_busy    (eng_busy),
        .eng_done    (eng_done),
        .eng_sum     (eng_sum),
        .exp_fixed   (exp_fixed),
        .exp_value   (exp_value),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    task automatic add_entry(int kind, addr_t addr, int count, word_t data, be_t be,
                             logic fixed, word_t expected);
        tab_kind[n_entries]  = kind;
        tab_addr[n_entries]  = addr;
        tab_count[n_entries] = count;
        tab_data[n_entries]  = data;
        tab_be[n_entries]    = be;
        tab_fixed[n_entries] = fixed;
        tab_exp[n_entries]   = expected;
        n_entries++;
    endtask

    task automatic build_table();
        // Whole memory gets a known pattern first
        add_entry(kind_fill, 8'h00, 256, 32'h1357_9bdf, 4'hf, 1'b0, '0);
        add_entry(kind_bus_wr, 8'h10, 1, 32'hdead_beef, 4'hf, 1'b0, '0);
        add_entry(kind_bus_rd, 8'h10, 1, '0, 4'h0, 1'b1, 32'hdead_beef);
        // Partial strobes, bytes 0 and 2 only
        add_entry(kind_bus_wr, 8'h11, 1, 32'hcafe_f00d, 4'hf, 1'b0, '0);
        add_entry(kind_bus_wr, 8'h11, 1, 32'h1122_3344, 4'b0101, 1'b0, '0);
        add_entry(kind_bus_rd, 8'h11, 1, '0, 4'h0, 1'b0, '0);
        add_entry(kind_bus_rd, 8'h11, 1, '0, 4'h0, 1'b1, 32'hca22_f044);
        add_entry(kind_bus_wr, 8'h12, 1, 32'h0bad_cafe, 4'b1000, 1'b0, '0);
        add_entry(kind_bus_rd, 8'h12, 1, '0, 4'h0, 1'b1, 32'h0b57_9bdf);
        // Short fill, then its edges from outside and inside
        add_entry(kind_fill, 8'h40, 8, 32'ha5a5_5a5a, 4'hf, 1'b0, '0);
        add_entry(kind_bus_rd, 8'h3f, 1, '0, 4'h0, 1'b1, 32'h1357_9bdf);
        add_entry(kind_bus_rd, 8'h40, 1, '0, 4'h0, 1'b1, 32'ha5a5_5a5a);
        add_entry(kind_bus_rd, 8'h47, 1, '0, 4'h0, 1'b1, 32'ha5a5_5a5a);
        add_entry(kind_bus_rd, 8'h48, 1, '0, 4'h0, 1'b1, 32'h1357_9bdf);
        for (int i = 0; i < 8; i++) begin
            add_entry(kind_rand_wr, addr_t'(128 + i), 1, '0, 4'hf, 1'b0, '0);
        end
        add_entry(kind_sum, 8'h80, 8, '0, 4'hf, 1'b0, '0);
        for (int i = 0; i < 4; i++) begin
            add_entry(kind_rand_wr, addr_t'(252 + i), 1, '0, 4'hf, 1'b0, '0);
        end
        // Asks for 16 words, only 4 remain below the top
        add_entry(kind_sum, 8'hfc, 16, '0, 4'hf, 1'b0, '0);
        add_entry(kind_sum_dup, 8'h80, 8, '0, 4'hf, 1'b0, '0);
        // The ignored fill must not have landed here
        add_entry(kind_bus_rd, 8'hfc, 1, '0, 4'h0, 1'b0, '0);
        add_entry(kind_sum, 8'h00, 256, '0, 4'hf, 1'b0, '0);
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_drive_slot();
        @(posedge clock_a);
        #1;
    endtask

    task automatic bus_transfer(logic wr, addr_t addr, word_t data, be_t be,
                                logic fixed, word_t expected);
        int waited;
        bus_sel   = 1'b1;
        bus_wr    = wr;
        bus_addr  = addr;
        bus_wdata = data;
        bus_be    = be;
        exp_fixed = fixed;
        exp_value = expected;
        next_drive_slot();
        bus_sel = 1'b0;
        waited  = 0;
        while (!bus_ack && waited < 4) begin
            next_drive_slot();
            waited++;
        end
        if (!bus_ack) begin
            $display("Bus access to 0x%02h was never acknowledged", addr);
            tb_errors++;
        end
        // Checker samples the ack cycle at this edge
        next_drive_slot();
    endtask

    task automatic engine_job(engine_op_t op, addr_t base, int count, word_t pattern,
                              logic dup_start);
        int waited;
        eng_start   = 1'b1;
        eng_op      = op;
        eng_base    = base;
        eng_count   = (`SPARTAN_ADDRW+1)'(count);
        eng_pattern = pattern;
        next_drive_slot();
        eng_start = 1'b0;
        if (dup_start) begin
            next_drive_slot();
            // Fill request while busy, must be dropped
            eng_start   = 1'b1;
            eng_op      = op_fill;
            eng_base    = 8'hfc;
            eng_count   = 'd4;
            eng_pattern = 32'hffff_ffff;
            next_drive_slot();
            eng_start = 1'b0;
        end
        waited = 0;
        while (!eng_done && waited < count + 10) begin
            next_drive_slot();
            waited++;
        end
        if (!eng_done) begin
            $display("Engine job at base 0x%02h never signalled done", base);
            tb_errors++;
        end
        // Quiet cycles so a stray second done gets caught
        repeat (3) next_drive_slot();
    endtask

    task automatic apply_entry(int idx);
        case (tab_kind[idx])
            kind_bus_wr:  bus_transfer(1'b1, tab_addr[idx], tab_data[idx], tab_be[idx],
                                       1'b0, '0);
            kind_rand_wr: bus_transfer(1'b1, tab_addr[idx], word_t'($urandom()), tab_be[idx],
                                       1'b0, '0);
            kind_bus_rd:  bus_transfer(1'b0, tab_addr[idx], '0, '0,
                                       tab_fixed[idx], tab_exp[idx]);
            kind_fill:    engine_job(op_fill, tab_addr[idx], tab_count[idx], tab_data[idx], 1'b0);
            kind_sum:     engine_job(op_sum, tab_addr[idx], tab_count[idx], '0, 1'b0);
            kind_sum_dup: engine_job(op_sum, tab_addr[idx], tab_count[idx], '0, 1'b1);
            default: begin
                $display("Unknown stimulus kind in table entry %0d", idx);
                tb_errors++;
            end
        endcase
    endtask

    initial begin
        void'($urandom(14951));
        rst_n       = 1'b0;
        bus_sel     = 1'b0;
        bus_wr      = 1'b0;
        bus_addr    = '0;
        bus_wdata   = '0;
        bus_be      = '0;
        eng_start   = 1'b0;
        eng_op      = op_fill;
        eng_base    = '0;
        eng_count   = '0;
        eng_pattern = '0;
        exp_fixed   = 1'b0;
        exp_value   = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clock_a);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            apply_entry(i);
        end
        repeat (2) next_drive_slot();
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count + tb_errors);
        if (fail_count == 0 && tb_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog, budget of count plus 10 cycles per table entry
    initial begin
        int budget;
        wait (table_ready);
        budget = 0;
        for (int i = 0; i < n_entries; i++) begin
            budget += tab_count[i] + 10;
        end
        #(budget * 100);
        $display("Timeout: run did not finish within %0d cycles", budget);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
spartan_pkg.sv
spartan_dpram.sv
spartan_bus_slave.sv
spartan_mem_engine.sv
spartan_ram_top.sv
tb_spartan_checker.sv
tb_spartan_ram.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the RAM subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_spartan_ram -f list.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0
